// File: common/tcb_pkg.sv
// bus widths and handshake timing, imported by every module facing the TCB channel

package tcb_pkg;

  ////////////////////////////////////////////////////////////
  // data path
  ////////////////////////////////////////////////////////////

  // word width of read and write data
  localparam int unsigned DAT_W = 32;

  // one enable per byte lane
  localparam int unsigned BEN_W = 4;

  // width of a single byte lane
  localparam int unsigned BYTE_W = DAT_W / BEN_W;

  ////////////////////////////////////////////////////////////
  // address and handshake
  ////////////////////////////////////////////////////////////

  // byte address, the low bits select a byte inside a word
  localparam int unsigned ADR_W = 16;

  // cycles from the transfer edge to valid read data
  // the response has no strobe, the manager counts cycles itself
  localparam int unsigned HSK_DLY = 1;

endpackage : tcb_pkg

// File: common/mem_pkg.sv
// bank array geometry, address field positions and bank FSM states for the scratch memory

package mem_pkg;

  ////////////////////////////////////////////////////////////
  // bank geometry
  ////////////////////////////////////////////////////////////

  // number of interleaved banks
  localparam int unsigned NUM_BANKS  = 4;
  localparam int unsigned BANK_IDX_W = 2;

  // words held in one bank
  localparam int unsigned BANK_DEPTH = 256;
  localparam int unsigned WORD_IDX_W = 8;

  // address fields, bits 3:2 pick the bank and bits 11:4 the word
  // bits 1:0 and everything above bit 11 are ignored, so addresses wrap
  localparam int unsigned BANK_LSB = 2;
  localparam int unsigned WORD_LSB = 4;

  // per bank FSM
  // merge is the extra cycle spent on a partial write
  typedef enum logic [0:0] {
    BANK_IDLE,
    BANK_MERGE
  } bank_state_t;

endpackage : mem_pkg

// File: rtl/tcb_common2independent.sv
// splits the common TCB request channel into read and write channels and merges the response

`timescale 1ns/1ps

module tcb_common2independent (
  input  logic                         clk,
  input  logic                         reset,
  // common channel from the manager
  input  logic                         vld,
  input  logic                         wen,
  input  logic [tcb_pkg::ADR_W-1:0]    adr,
  input  logic [tcb_pkg::BEN_W-1:0]    ben,
  input  logic [tcb_pkg::DAT_W-1:0]    wdt,
  output logic                         rdy,
  output logic [tcb_pkg::DAT_W-1:0]    rdt,
  // read channel, no write data travels here
  output logic                         rdc_vld,
  output logic [tcb_pkg::ADR_W-1:0]    rdc_adr,
  input  logic                         rdc_rdy,
  input  logic [tcb_pkg::DAT_W-1:0]    rdc_rdt,
  // write channel
  output logic                         wrc_vld,
  output logic [tcb_pkg::ADR_W-1:0]    wrc_adr,
  output logic [tcb_pkg::BEN_W-1:0]    wrc_ben,
  output logic [tcb_pkg::DAT_W-1:0]    wrc_wdt,
  input  logic                         wrc_rdy,
  input  logic [tcb_pkg::DAT_W-1:0]    wrc_rdt
);

  import tcb_pkg::*;

  // history of accepted reads, one bit per response delay cycle
  logic [HSK_DLY-1:0] ren_dly;

  ////////////////////////////////////////////////////////////
  // request path
  ////////////////////////////////////////////////////////////

  // valid goes to one channel only, picked by write enable
  assign rdc_vld = vld & ~wen;
  assign wrc_vld = vld &  wen;

  // ready comes back from the channel the request is aimed at
  assign rdy = wen ? wrc_rdy : rdc_rdy;

  // request payload
  assign rdc_adr = adr;
  assign wrc_adr = adr;
  assign wrc_ben = ben;
  assign wrc_wdt = wdt;

  ////////////////////////////////////////////////////////////
  // response path
  ////////////////////////////////////////////////////////////

  // shift in a one for every accepted read
  always_ff @(posedge clk) begin
    if (reset) begin
      ren_dly <= '0;
    end else begin
      ren_dly[0] <= vld & rdy & ~wen;
      for (int i = 1; i < HSK_DLY; i++) begin
        ren_dly[i] <= ren_dly[i-1];
      end
    end
  end

  // read data for reads, old word for writes
  assign rdt = ren_dly[HSK_DLY-1] ? rdc_rdt : wrc_rdt;

  // a merge lasts one cycle, so a stalled request is taken on the next edge
  a_stall_one_cycle: assert property (@(posedge clk) disable iff (reset)
    vld && !rdy |=> rdy);

  // a stalled request is held by the manager until accepted
  a_hold_request: assert property (@(posedge clk) disable iff (reset)
    vld && !rdy |=> vld && $stable(wen) && $stable(adr));

endmodule : tcb_common2independent

// File: bank_array/tcb_bank_decoder.sv
// steers read and write channel requests to the addressed bank and returns that bank's ready

`timescale 1ns/1ps

module tcb_bank_decoder (
  // read channel
  input  logic                                   rdc_vld,
  input  logic [tcb_pkg::ADR_W-1:0]              rdc_adr,
  output logic                                   rdc_rdy,
  // write channel
  input  logic                                   wrc_vld,
  input  logic [tcb_pkg::ADR_W-1:0]              wrc_adr,
  input  logic [tcb_pkg::BEN_W-1:0]              wrc_ben,
  input  logic [tcb_pkg::DAT_W-1:0]              wrc_wdt,
  output logic                                   wrc_rdy,
  // bank side, one bit per bank
  input  logic [mem_pkg::NUM_BANKS-1:0]          bank_rdy,
  output logic [mem_pkg::NUM_BANKS-1:0]          bank_rd_vld,
  output logic [mem_pkg::NUM_BANKS-1:0]          bank_wr_vld,
  // shared by all banks
  output logic [mem_pkg::WORD_IDX_W-1:0]         bank_rd_idx,
  output logic [mem_pkg::WORD_IDX_W-1:0]         bank_wr_idx,
  output logic [tcb_pkg::BEN_W-1:0]              bank_ben,
  output logic [tcb_pkg::DAT_W-1:0]              bank_wdt,
  // accepted transfers, for the collector
  output logic [mem_pkg::NUM_BANKS-1:0]          bank_rd_acc,
  output logic [mem_pkg::NUM_BANKS-1:0]          bank_wr_acc
);

  import mem_pkg::*;

  // bank field of each channel address
  logic [BANK_IDX_W-1:0] rd_bank;
  logic [BANK_IDX_W-1:0] wr_bank;

  ////////////////////////////////////////////////////////////
  // address fields
  ////////////////////////////////////////////////////////////

  // consecutive words land in consecutive banks
  assign rd_bank = rdc_adr[BANK_LSB +: BANK_IDX_W];
  assign wr_bank = wrc_adr[BANK_LSB +: BANK_IDX_W];

  // word inside the bank, upper address bits dropped
  assign bank_rd_idx = rdc_adr[WORD_LSB +: WORD_IDX_W];
  assign bank_wr_idx = wrc_adr[WORD_LSB +: WORD_IDX_W];

  // write payload is broadcast, only the valid bank takes it
  assign bank_ben = wrc_ben;
  assign bank_wdt = wrc_wdt;

  ////////////////////////////////////////////////////////////
  // handshake steering
  ////////////////////////////////////////////////////////////

  // one-hot valid towards the addressed bank
  always_comb begin
    bank_rd_vld = '0;
    bank_wr_vld = '0;
    bank_rd_vld[rd_bank] = rdc_vld;
    bank_wr_vld[wr_bank] = wrc_vld;
  end

  // ready does not depend on valid, a stalled bank only blocks its own requests
  assign rdc_rdy = bank_rdy[rd_bank];
  assign wrc_rdy = bank_rdy[wr_bank];

  // handshake per bank
  assign bank_rd_acc = bank_rd_vld & bank_rdy;
  assign bank_wr_acc = bank_wr_vld & bank_rdy;

endmodule : tcb_bank_decoder

// File: bank_array/tcb_sram_bank.sv
// one word wide memory bank with read before write, partial writes take one merge cycle

`timescale 1ns/1ps

module tcb_sram_bank (
  input  logic                            clk,
  input  logic                            reset,
  // requests from the decoder
  input  logic                            rd_vld,
  input  logic                            wr_vld,
  input  logic [mem_pkg::WORD_IDX_W-1:0]  rd_idx,
  input  logic [mem_pkg::WORD_IDX_W-1:0]  wr_idx,
  input  logic [tcb_pkg::BEN_W-1:0]       ben,
  input  logic [tcb_pkg::DAT_W-1:0]       wdt,
  output logic                            rdy,
  // responses, valid one cycle after the transfer
  output logic [tcb_pkg::DAT_W-1:0]       rd_rdt,
  output logic [tcb_pkg::DAT_W-1:0]       wr_rdt
);

  import tcb_pkg::*;
  import mem_pkg::*;

  // storage
  logic [DAT_W-1:0] mem [BANK_DEPTH];

  // FSM
  bank_state_t state;

  // handshakes
  logic rd_acc;
  logic wr_acc;
  logic ben_full;

  // held partial write
  logic [WORD_IDX_W-1:0] mrg_idx;
  logic [BEN_W-1:0]      mrg_ben;
  logic [DAT_W-1:0]      mrg_dat;
  logic [DAT_W-1:0]      mrg_wdt;

  ////////////////////////////////////////////////////////////
  // handshake and FSM
  ////////////////////////////////////////////////////////////

  // the merge cycle is the only time the bank stalls
  assign rdy = (state == BANK_IDLE);

  assign rd_acc   = rd_vld & rdy;
  assign wr_acc   = wr_vld & rdy;
  assign ben_full = &ben;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= BANK_IDLE;
    end else begin
      case (state)
        BANK_IDLE: begin
          // partial write, old word is fetched now and merged next cycle
          if (wr_acc && !ben_full) begin
            state <= BANK_MERGE;
          end
        end
        BANK_MERGE: state <= BANK_IDLE;
        default:    state <= BANK_IDLE;
      endcase
    end
  end

  // capture the partial write for the merge cycle
  always_ff @(posedge clk) begin
    if (wr_acc && !ben_full) begin
      mrg_idx <= wr_idx;
      mrg_ben <= ben;
      mrg_dat <= wdt;
    end
  end

  ////////////////////////////////////////////////////////////
  // merge
  ////////////////////////////////////////////////////////////

  // old word sits in wr_rdt for the whole merge cycle
  // enabled lanes take the new byte, the rest keep the old one
  always_comb begin
    for (int b = 0; b < BEN_W; b++) begin
      mrg_wdt[b*BYTE_W +: BYTE_W] = mrg_ben[b] ? mrg_dat[b*BYTE_W +: BYTE_W]
                                               : wr_rdt[b*BYTE_W +: BYTE_W];
    end
  end

  ////////////////////////////////////////////////////////////
  // memory access
  ////////////////////////////////////////////////////////////

  // write port, merge and full write never coincide
  always_ff @(posedge clk) begin
    if (state == BANK_MERGE) begin
      mem[mrg_idx] <= mrg_wdt;
    end else if (wr_acc && ben_full) begin
      mem[wr_idx] <= wdt;
    end
  end

  // read before write, both ports return the content before this edge
  always_ff @(posedge clk) begin
    if (rd_acc) begin
      rd_rdt <= mem[rd_idx];
    end
    if (wr_acc) begin
      wr_rdt <= mem[wr_idx];
    end
  end

  // the splitter sends one channel at a time
  a_single_vld: assert property (@(posedge clk) disable iff (reset)
    !(rd_vld && wr_vld));

endmodule : tcb_sram_bank

// File: bank_array/tcb_bank_collector.sv
// returns the addressed bank's response to the read and write channels one cycle after transfer

`timescale 1ns/1ps

module tcb_bank_collector (
  input  logic                                           clk,
  input  logic                                           reset,
  // accepted transfers from the decoder
  input  logic [mem_pkg::NUM_BANKS-1:0]                  bank_rd_acc,
  input  logic [mem_pkg::NUM_BANKS-1:0]                  bank_wr_acc,
  // bank responses
  input  logic [mem_pkg::NUM_BANKS-1:0][tcb_pkg::DAT_W-1:0] bank_rd_rdt,
  input  logic [mem_pkg::NUM_BANKS-1:0][tcb_pkg::DAT_W-1:0] bank_wr_rdt,
  // channel responses
  output logic [tcb_pkg::DAT_W-1:0]                      rdc_rdt,
  output logic [tcb_pkg::DAT_W-1:0]                      wrc_rdt
);

  import mem_pkg::*;

  // bank that took the last transfer on each channel
  logic [BANK_IDX_W-1:0] rd_sel;
  logic [BANK_IDX_W-1:0] wr_sel;

  // one-hot to binary
  function automatic logic [BANK_IDX_W-1:0] onehot_enc(input logic [NUM_BANKS-1:0] oh);
    logic [BANK_IDX_W-1:0] idx;
    idx = '0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      if (oh[i]) begin
        idx = idx | BANK_IDX_W'(i);
      end
    end
    return idx;
  endfunction

  // index only moves on a transfer, otherwise the last one is kept
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_sel <= '0;
      wr_sel <= '0;
    end else begin
      if (|bank_rd_acc) rd_sel <= onehot_enc(bank_rd_acc);
      if (|bank_wr_acc) wr_sel <= onehot_enc(bank_wr_acc);
    end
  end

  // response cycle mux
  assign rdc_rdt = bank_rd_rdt[rd_sel];
  assign wrc_rdt = bank_wr_rdt[wr_sel];

  // at most one bank per channel takes a transfer
  a_onehot_acc: assert property (@(posedge clk) disable iff (reset)
    $onehot0(bank_rd_acc) && $onehot0(bank_wr_acc));

endmodule : tcb_bank_collector

// File: rtl/tcb_banked_mem_top.sv
// top level of the banked scratch memory, exposes one common TCB channel to the manager

`timescale 1ns/1ps

module tcb_banked_mem_top (
  input  logic                       clk,
  input  logic                       reset,
  // common channel
  input  logic                       vld,
  input  logic                       wen,
  input  logic [tcb_pkg::ADR_W-1:0]  adr,
  input  logic [tcb_pkg::BEN_W-1:0]  ben,
  input  logic [tcb_pkg::DAT_W-1:0]  wdt,
  output logic                       rdy,
  output logic [tcb_pkg::DAT_W-1:0]  rdt
);

  import tcb_pkg::*;
  import mem_pkg::*;

  ////////////////////////////////////////////////////////////
  // wiring
  ////////////////////////////////////////////////////////////

  // read channel
  logic             rdc_vld;
  logic [ADR_W-1:0] rdc_adr;
  logic             rdc_rdy;
  logic [DAT_W-1:0] rdc_rdt;

  // write channel
  logic             wrc_vld;
  logic [ADR_W-1:0] wrc_adr;
  logic [BEN_W-1:0] wrc_ben;
  logic [DAT_W-1:0] wrc_wdt;
  logic             wrc_rdy;
  logic [DAT_W-1:0] wrc_rdt;

  // bank side
  logic [NUM_BANKS-1:0]            bank_rdy;
  logic [NUM_BANKS-1:0]            bank_rd_vld;
  logic [NUM_BANKS-1:0]            bank_wr_vld;
  logic [WORD_IDX_W-1:0]           bank_rd_idx;
  logic [WORD_IDX_W-1:0]           bank_wr_idx;
  logic [BEN_W-1:0]                bank_ben;
  logic [DAT_W-1:0]                bank_wdt;
  logic [NUM_BANKS-1:0]            bank_rd_acc;
  logic [NUM_BANKS-1:0]            bank_wr_acc;
  logic [NUM_BANKS-1:0][DAT_W-1:0] bank_rd_rdt;
  logic [NUM_BANKS-1:0][DAT_W-1:0] bank_wr_rdt;

  // common to independent channels
  tcb_common2independent u_split (
    .clk, .reset,
    .vld, .wen, .adr, .ben, .wdt, .rdy, .rdt,
    .rdc_vld, .rdc_adr, .rdc_rdy, .rdc_rdt,
    .wrc_vld, .wrc_adr, .wrc_ben, .wrc_wdt, .wrc_rdy, .wrc_rdt
  );

  // address decode and bank steering
  tcb_bank_decoder u_dec (
    .rdc_vld, .rdc_adr, .rdc_rdy,
    .wrc_vld, .wrc_adr, .wrc_ben, .wrc_wdt, .wrc_rdy,
    .bank_rdy, .bank_rd_vld, .bank_wr_vld,
    .bank_rd_idx, .bank_wr_idx, .bank_ben, .bank_wdt,
    .bank_rd_acc, .bank_wr_acc
  );

  // interleaved banks
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    tcb_sram_bank u_bank (
      .clk    (clk),
      .reset  (reset),
      .rd_vld (bank_rd_vld[b]),
      .wr_vld (bank_wr_vld[b]),
      .rd_idx (bank_rd_idx),
      .wr_idx (bank_wr_idx),
      .ben    (bank_ben),
      .wdt    (bank_wdt),
      .rdy    (bank_rdy[b]),
      .rd_rdt (bank_rd_rdt[b]),
      .wr_rdt (bank_wr_rdt[b])
    );
  end

  // response collection
  tcb_bank_collector u_col (
    .clk, .reset,
    .bank_rd_acc, .bank_wr_acc,
    .bank_rd_rdt, .bank_wr_rdt,
    .rdc_rdt, .wrc_rdt
  );

endmodule : tcb_banked_mem_top

// File: sim/tcb_banked_mem_checker.sv
// testbench checker, watches DUT handshakes and compares each response with its queued expected word

`timescale 1ns/1ps

module tcb_banked_mem_checker (
  input  logic                       clk,
  input  logic                       reset,
  // DUT common channel, observed only
  input  logic                       vld,
  input  logic                       wen,
  input  logic [tcb_pkg::ADR_W-1:0]  adr,
  input  logic [tcb_pkg::BEN_W-1:0]  ben,
  input  logic                       rdy,
  input  logic [tcb_pkg::DAT_W-1:0]  rdt,
  // running totals for the final report
  output int                         rsp_cnt,
  output int                         err_cnt,
  output int                         test_pass,
  output int                         test_fail
);

  import tcb_pkg::*;

  // expected responses in transfer order, filled by the driver
  logic [8*16-1:0]  name_q [$];
  logic             chk_q  [$];
  logic [DAT_W-1:0] exp_q  [$];
  logic             last_q [$];

  // a response is due on the next edge
  logic rsp_due;
  logic rsp_wen;
  // bank busy merging a partial write in this cycle
  logic       mrg_pend;
  logic [1:0] mrg_bank;
  // per test tallies
  int   test_err;
  int   test_rsp;

  // called by the driver at each transfer
  task automatic push_expect(input logic [8*16-1:0] name, input logic chk,
                             input logic [DAT_W-1:0] exp, input logic last);
    name_q.push_back(name);
    chk_q.push_back(chk);
    exp_q.push_back(exp);
    last_q.push_back(last);
  endtask

  // bank field of a byte address, bits 3:2
  function automatic logic [1:0] bank_of(input logic [ADR_W-1:0] a);
    return a[3:2];
  endfunction

  ////////////////////////////////////////////////////////////
  // response compare
  ////////////////////////////////////////////////////////////

  task automatic check_response();
    logic [8*16-1:0]  name;
    logic             chk;
    logic [DAT_W-1:0] exp;
    logic             last;
    if (exp_q.size() == 0) begin
      $display("response at %0d ns arrived with no expected value queued", $time);
      err_cnt++;
    end else begin
      name = name_q.pop_front();
      chk  = chk_q.pop_front();
      exp  = exp_q.pop_front();
      last = last_q.pop_front();
      rsp_cnt++;
      test_rsp++;
      // chk low marks a first write whose old word is undefined
      if (chk && rdt !== exp) begin
        $display("FAILED %0d ns: test %0s %s response %h, expected %h", $time, name,
                 rsp_wen ? "write" : "read", rdt, exp);
        err_cnt++;
        test_err++;
      end
      // one result line when the test's last response is in
      if (last) begin
        if (test_err == 0) begin
          $display("test %0s passed, %0d responses", name, test_rsp);
          test_pass++;
        end else begin
          $display("test %0s failed, %0d of %0d responses wrong", name, test_err, test_rsp);
          test_fail++;
        end
        test_err = 0;
        test_rsp = 0;
      end
    end
  endtask

  // ready is low only towards a bank in its merge cycle
  task automatic check_ready();
    logic exp_rdy;
    exp_rdy = !(mrg_pend && bank_of(adr) == mrg_bank);
    if (rdy !== exp_rdy) begin
      $display("FAILED %0d ns: ready %b for bank %0d, expected %b", $time, rdy,
               bank_of(adr), exp_rdy);
      err_cnt++;
    end
  endtask

  // rdt is sampled HSK_DLY cycles after the transfer edge
  always @(posedge clk) begin
    if (reset) begin
      rsp_due   <= 1'b0;
      rsp_wen   <= 1'b0;
      mrg_pend  <= 1'b0;
      mrg_bank  <= '0;
      rsp_cnt   = 0;
      err_cnt   = 0;
      test_pass = 0;
      test_fail = 0;
      test_err  = 0;
      test_rsp  = 0;
    end else begin
      if (rsp_due) begin
        check_response();
      end
      if (vld) begin
        check_ready();
      end
      rsp_due  <= vld && rdy;
      rsp_wen  <= wen;
      // a write without all four byte enables costs its bank one merge cycle
      mrg_pend <= vld && rdy && wen && !(&ben);
      mrg_bank <= bank_of(adr);
    end
  end

endmodule : tcb_banked_mem_checker

// File: sim/tcb_banked_mem_tb.sv
// testbench top, reads the stim file, drives the common channel and reports the checker's totals

`timescale 1ns/1ps

module tcb_banked_mem_tb;

  import tcb_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int RST_CYCLES = 8;
  localparam int MAX_LINES  = 64;

  // DUT ports
  logic             clk;
  logic             reset;
  logic             vld;
  logic             wen;
  logic [ADR_W-1:0] adr;
  logic [BEN_W-1:0] ben;
  logic [DAT_W-1:0] wdt;
  logic             rdy;
  logic [DAT_W-1:0] rdt;

  // checker totals
  int rsp_cnt;
  int err_cnt;
  int test_pass;
  int test_fail;

  // stimulus table, one entry per request line
  logic [8*16-1:0]  t_name [MAX_LINES];
  logic             t_wen  [MAX_LINES];
  logic [ADR_W-1:0] t_adr  [MAX_LINES];
  logic [BEN_W-1:0] t_ben  [MAX_LINES];
  logic [DAT_W-1:0] t_wdt  [MAX_LINES];
  logic             t_chk  [MAX_LINES];
  logic [DAT_W-1:0] t_exp  [MAX_LINES];
  int               n_lines;
  int               load_err;
  logic             loaded;
  int unsigned      seed_val;
  int unsigned      rnd;

  tcb_banked_mem_top DUT (
    .clk, .reset, .vld, .wen, .adr, .ben, .wdt, .rdy, .rdt
  );

  tcb_banked_mem_checker u_chk (
    .clk, .reset, .vld, .wen, .adr, .ben, .rdy, .rdt,
    .rsp_cnt, .err_cnt, .test_pass, .test_fail
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // stimulus file
  ////////////////////////////////////////////////////////////

  task automatic load_stim();
    int    fd;
    int    cnt;
    string line;
    fd = $fopen("sim/tcb_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file sim/tcb_stim.txt");
    end else begin
      while (!$feof(fd) && n_lines < MAX_LINES) begin
        line = "";
        void'($fgets(line, fd));
        cnt = $sscanf(line, "%s %h %h %h %h %h %h", t_name[n_lines], t_wen[n_lines],
                      t_adr[n_lines], t_ben[n_lines], t_wdt[n_lines], t_chk[n_lines],
                      t_exp[n_lines]);
        // comment lines start with a hash, blank lines scan nothing
        if (cnt == 7 && line[0] != "#") begin
          n_lines++;
        end else if (cnt > 0 && line[0] != "#") begin
          $display("stimulus line could not be parsed: %s", line);
          load_err++;
        end
      end
      $fclose(fd);
    end
  endtask

  // last line of a test closes its result line in the checker
  function automatic logic is_last(input int i);
    if (i == n_lines - 1) begin
      return 1'b1;
    end else begin
      return t_name[i+1] != t_name[i];
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // request driver
  ////////////////////////////////////////////////////////////

  task automatic run_requests();
    int gap;
    for (int i = 0; i < n_lines; i++) begin
      // idle cycles only between tests, requests inside a test go back to back
      if (i > 0 && t_name[i] != t_name[i-1]) begin
        gap = $urandom % 3;
        vld <= 1'b0;
        repeat (gap) @(posedge clk);
      end
      vld <= 1'b1;
      wen <= t_wen[i];
      adr <= t_adr[i];
      ben <= t_ben[i];
      wdt <= t_wdt[i];
      // hold until the handshake edge
      @(posedge clk);
      while (!rdy) @(posedge clk);
      u_chk.push_expect(t_name[i], t_chk[i], t_exp[i], is_last(i));
    end
    vld <= 1'b0;
  endtask

  initial begin
    clk      = 1'b0;
    reset    = 1'b1;
    vld      = 1'b0;
    wen      = 1'b0;
    adr      = '0;
    ben      = '0;
    wdt      = '0;
    n_lines  = 0;
    load_err = 0;
    loaded   = 1'b0;
    seed_val = 32'hf3099eba;
    rnd      = $urandom(seed_val);
    load_stim();
    loaded = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    reset <= 1'b0;
    run_requests();
    // wait for the last response to be compared
    wait (rsp_cnt >= n_lines);
    @(posedge clk);
    $display("tests passed %0d, failed %0d, responses %0d, mismatches %0d",
             test_pass, test_fail, rsp_cnt, err_cnt);
    if (n_lines > 0 && load_err == 0 && err_cnt == 0 && test_fail == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // watchdog, four cycles per request line on top of reset
  initial begin
    wait (loaded);
    #((RST_CYCLES + n_lines * 4) * CLK_PERIOD);
    $display("the run timed out before every response was checked");
    $display("Done: errors found");
    $finish;
  end

endmodule : tcb_banked_mem_tb

// File: sim/tcb_stim.txt
# columns: test wen adr ben wdt chk exp, all but test in hex
# chk 0 skips the compare, used where the old word was never written
full_wr_rd    1 0000 f 11111111 0 00000000
full_wr_rd    1 0004 f 22222222 0 00000000
full_wr_rd    1 0008 f 33333333 0 00000000
full_wr_rd    1 000c f 44444444 0 00000000
full_wr_rd    0 0008 0 00000000 1 33333333
full_wr_rd    0 000c 0 00000000 1 44444444
partial_merge 1 0010 f 01234567 0 00000000
partial_merge 1 0010 3 deadbeef 1 01234567
partial_merge 0 0010 0 00000000 1 0123beef
interleave    0 1004 0 00000000 1 22222222
interleave    1 f008 f 55555555 1 33333333
interleave    0 000a 0 00000000 1 55555555
interleave    0 100c 0 00000000 1 44444444
mixed_b2b     1 0004 f 12121212 1 22222222
mixed_b2b     0 0000 0 00000000 1 11111111
mixed_b2b     1 000c f 66666666 1 44444444
mixed_b2b     0 0004 0 00000000 1 12121212
merge_stall   1 0008 6 00bbcc00 1 55555555
merge_stall   0 0008 0 00000000 1 55bbcc55
merge_stall   1 0000 2 00003300 1 11111111
merge_stall   1 000c f 77777777 1 66666666
merge_stall   0 0000 0 00000000 1 11113311

// File: sources.f
common/tcb_pkg.sv
common/mem_pkg.sv
rtl/tcb_common2independent.sv
bank_array/tcb_bank_decoder.sv
bank_array/tcb_sram_bank.sv
bank_array/tcb_bank_collector.sv
rtl/tcb_banked_mem_top.sv
sim/tcb_banked_mem_checker.sv
sim/tcb_banked_mem_tb.sv
